//--- logic/rob_commit.sv
// head pointers and in-order retirement of up to two entries per cycle, thread 1 first
`timescale 1ns/1ps

module rob_commit (
	input  logic clock,
	input  logic reset,
	input  rob_entry_pkg::rob_entry_t t1_head_entry,
	input  rob_entry_pkg::rob_entry_t t1_next_entry,
	input  rob_entry_pkg::rob_entry_t t2_head_entry,
	input  rob_entry_pkg::rob_entry_t t2_next_entry,
	output rob_entry_pkg::commit_slot_t commit1,
	output rob_entry_pkg::commit_slot_t commit2,
	output rob_config_pkg::rob_index_t t1_head,
	output rob_config_pkg::rob_index_t t2_head,
	output rob_config_pkg::entry_mask_t t1_free,
	output rob_config_pkg::entry_mask_t t2_free,
	output logic t1_squash,
	output logic t2_squash,
	output rob_config_pkg::rob_index_t t1_new_head,
	output rob_config_pkg::rob_index_t t2_new_head
);

	rob_entry_pkg::rob_entry_t c1_entry;
	rob_entry_pkg::rob_entry_t c2_entry;
	rob_config_pkg::rob_index_t t1_head_next;
	rob_config_pkg::rob_index_t t2_head_next;
	logic c1_thread1;
	logic c2_thread1;
	logic [1:0] t1_count;	// entries retired from each thread this cycle
	logic [1:0] t2_count;
	logic [2:0] total;

	function automatic logic ready(rob_entry_pkg::rob_entry_t entry);
		return entry.occupied && entry.executed;
	endfunction

	function automatic logic redirects(rob_entry_pkg::rob_entry_t entry);
		return entry.inst.is_branch && entry.mispredict;
	endfunction

	function automatic rob_entry_pkg::commit_slot_t make_slot(
		logic valid,
		logic is_thread1,
		rob_entry_pkg::rob_entry_t entry
	);
		rob_entry_pkg::commit_slot_t slot;
		slot = '0;
		if (valid)
		begin
			slot.valid = 1'b1;
			slot.is_thread1 = is_thread1;
			slot.pc = entry.inst.pc;
			slot.target = entry.target;
			slot.is_branch = entry.inst.is_branch;
			slot.mispredict = entry.mispredict;
			slot.arn_dest = entry.inst.arn_dest;
			slot.prn_dest = entry.inst.prn_dest;
		end
		return slot;
	endfunction

	function automatic logic squashes(rob_entry_pkg::commit_slot_t slot, logic thread1);
		return slot.valid && slot.is_thread1 == thread1 && slot.is_branch && slot.mispredict;
	endfunction

	always_comb
	begin
		t1_count = 2'd0;
		t2_count = 2'd0;
		c1_entry = t1_head_entry;
		c1_thread1 = 1'b1;
		c2_entry = t2_head_entry;
		c2_thread1 = 1'b0;
		if (ready(t1_head_entry))
		begin
			t1_count = 2'd1;
			// a redirecting branch ends its thread's group
			if (ready(t1_next_entry) && !redirects(t1_head_entry))
			begin
				c2_entry = t1_next_entry;
				c2_thread1 = 1'b1;
				t1_count = 2'd2;
			end
			else if (ready(t2_head_entry))
				t2_count = 2'd1;
		end
		else if (ready(t2_head_entry))
		begin
			c1_entry = t2_head_entry;
			c1_thread1 = 1'b0;
			t2_count = 2'd1;
			if (ready(t2_next_entry) && !redirects(t2_head_entry))
			begin
				c2_entry = t2_next_entry;
				t2_count = 2'd2;
			end
		end
	end

	assign total = t1_count + t2_count;
	assign commit1 = make_slot(total != 3'd0, c1_thread1, c1_entry);
	assign commit2 = make_slot(total == 3'd2, c2_thread1, c2_entry);

	assign t1_head_next = t1_head + 1'b1;
	assign t2_head_next = t2_head + 1'b1;

	assign t1_free = (t1_count != 2'd0 ? rob_config_pkg::entry_mask_t'(1) << t1_head : '0)
		| (t1_count == 2'd2 ? rob_config_pkg::entry_mask_t'(1) << t1_head_next : '0);
	assign t2_free = (t2_count != 2'd0 ? rob_config_pkg::entry_mask_t'(1) << t2_head : '0)
		| (t2_count == 2'd2 ? rob_config_pkg::entry_mask_t'(1) << t2_head_next : '0);

	assign t1_squash = squashes(commit1, 1'b1) || squashes(commit2, 1'b1);
	assign t2_squash = squashes(commit1, 1'b0) || squashes(commit2, 1'b0);

	// head after this cycle's retirement, also where the tail lands on a squash
	assign t1_new_head = t1_head + t1_count;
	assign t2_new_head = t2_head + t2_count;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			t1_head <= '0;
			t2_head <= '0;
		end
		else
		begin
			t1_head <= t1_new_head;
			t2_head <= t2_new_head;
		end
	end

endmodule

//--- logic/rob_complete.sv
// turns the two functional-unit reports into per-entry write enables and results for each thread
`timescale 1ns/1ps

module rob_complete (
	input  rob_entry_pkg::completion_t fu1,
	input  rob_entry_pkg::completion_t fu2,
	output rob_config_pkg::entry_mask_t t1_done,
	output rob_config_pkg::entry_mask_t t2_done,
	output rob_entry_pkg::result_t [rob_config_pkg::ENTRY_COUNT-1:0] t1_result,
	output rob_entry_pkg::result_t [rob_config_pkg::ENTRY_COUNT-1:0] t2_result
);

	rob_entry_pkg::completion_t reports [2];
	rob_entry_pkg::result_t report_result;
	rob_config_pkg::rob_index_t index;
	logic thread2;

	assign reports[0] = fu1;
	assign reports[1] = fu2;

	always_comb
	begin
		t1_done = '0;
		t2_done = '0;
		t1_result = '0;
		t2_result = '0;
		index = '0;
		thread2 = 1'b0;
		report_result = '0;
		// fu2 is decoded last so it overrides fu1 on the same entry
		for (int p = 0; p < 2; p++)
		begin
			if (reports[p].valid)
			begin
				{thread2, index} = reports[p].tag;
				report_result = '{mispredict: reports[p].mispredict, target: reports[p].target};
				if (thread2)
				begin
					t2_done[index] = 1'b1;
					t2_result[index] = report_result;
				end
				else
				begin
					t1_done[index] = 1'b1;
					t1_result[index] = report_result;
				end
			end
		end
	end

endmodule

//--- logic/rob_config_pkg.sv
// widths and index types of the reorder buffer, shared by every block of the buffer and the core side
package rob_config_pkg;

	// entries in each thread partition
	localparam int ENTRY_COUNT = 16;

	typedef logic [63:0] pc_t;	// program counter
	typedef logic [4:0] arn_t;	// architected register number
	typedef logic [5:0] prn_t;	// physical register number, file of 64

	// position inside one partition, wraps from 15 to 0 on its own
	typedef logic [3:0] rob_index_t;

	// tag handed out at dispatch, upper bit set for thread 2
	typedef logic [4:0] rob_tag_t;

	// one bit per entry of a partition
	typedef logic [ENTRY_COUNT-1:0] entry_mask_t;

endpackage

//--- logic/rob_dispatch.sv
// tail pointers of both partitions; accepts dispatch pairs, hands out tags and raises the full flags
`timescale 1ns/1ps

module rob_dispatch (
	input  logic clock,
	input  logic reset,
	input  logic is_thread1,
	input  logic inst1_load,
	input  logic inst2_load,
	input  rob_config_pkg::rob_index_t t1_head,
	input  rob_config_pkg::rob_index_t t2_head,
	input  logic t1_tail_occupied,
	input  logic t2_tail_occupied,
	input  logic t1_squash,
	input  logic t2_squash,
	input  rob_config_pkg::rob_index_t t1_new_head,
	input  rob_config_pkg::rob_index_t t2_new_head,
	output rob_config_pkg::rob_tag_t inst1_tag,
	output rob_config_pkg::rob_tag_t inst2_tag,
	output rob_config_pkg::entry_mask_t t1_load1,
	output rob_config_pkg::entry_mask_t t1_load2,
	output rob_config_pkg::entry_mask_t t2_load1,
	output rob_config_pkg::entry_mask_t t2_load2,
	output rob_config_pkg::rob_index_t t1_tail,
	output rob_config_pkg::rob_index_t t2_tail,
	output logic t1_full,
	output logic t2_full
);

	rob_config_pkg::rob_index_t t1_tail_next;
	rob_config_pkg::rob_index_t t2_tail_next;
	rob_config_pkg::rob_index_t sel_tail;
	logic pair_valid;
	logic t1_accept;
	logic t2_accept;

	// fewer than two free slots left; head == tail is either empty or completely full
	function automatic logic partition_full(
		rob_config_pkg::rob_index_t head,
		rob_config_pkg::rob_index_t tail,
		logic tail_occupied
	);
		rob_config_pkg::rob_index_t tail_plus;
		tail_plus = tail + 1'b1;
		return (tail_plus == head) || (tail == head && tail_occupied);
	endfunction

	assign t1_tail_next = t1_tail + 1'b1;
	assign t2_tail_next = t2_tail + 1'b1;

	assign t1_full = partition_full(t1_head, t1_tail, t1_tail_occupied);
	assign t2_full = partition_full(t2_head, t2_tail, t2_tail_occupied);

	// only whole pairs go in, and never into a thread being squashed
	assign pair_valid = inst1_load && inst2_load;
	assign t1_accept = pair_valid && is_thread1 && !t1_full && !t1_squash;
	assign t2_accept = pair_valid && !is_thread1 && !t2_full && !t2_squash;

	assign sel_tail = is_thread1 ? t1_tail : t2_tail;
	assign inst1_tag = {!is_thread1, sel_tail};
	assign inst2_tag = {!is_thread1, is_thread1 ? t1_tail_next : t2_tail_next};

	assign t1_load1 = t1_accept ? rob_config_pkg::entry_mask_t'(1) << t1_tail : '0;
	assign t1_load2 = t1_accept ? rob_config_pkg::entry_mask_t'(1) << t1_tail_next : '0;
	assign t2_load1 = t2_accept ? rob_config_pkg::entry_mask_t'(1) << t2_tail : '0;
	assign t2_load2 = t2_accept ? rob_config_pkg::entry_mask_t'(1) << t2_tail_next : '0;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			t1_tail <= '0;
			t2_tail <= '0;
		end
		else
		begin
			if (t1_squash)
				t1_tail <= t1_new_head;	// partition is empty again
			else if (t1_accept)
				t1_tail <= t1_tail + 2'd2;
			if (t2_squash)
				t2_tail <= t2_new_head;
			else if (t2_accept)
				t2_tail <= t2_tail + 2'd2;
		end
	end

endmodule

//--- logic/rob_entry_bank.sv
// entry storage of one thread partition; loads dispatches, records results, frees and squashes
`timescale 1ns/1ps

module rob_entry_bank (
	input  logic clock,
	input  logic reset,
	input  rob_entry_pkg::dispatch_slot_t inst1,
	input  rob_entry_pkg::dispatch_slot_t inst2,
	input  rob_config_pkg::entry_mask_t load1,
	input  rob_config_pkg::entry_mask_t load2,
	input  rob_config_pkg::entry_mask_t done,
	input  rob_entry_pkg::result_t [rob_config_pkg::ENTRY_COUNT-1:0] result,
	input  rob_config_pkg::entry_mask_t free,
	input  logic squash,
	input  rob_config_pkg::rob_index_t head,
	input  rob_config_pkg::rob_index_t tail,
	output rob_entry_pkg::rob_entry_t head_entry,
	output rob_entry_pkg::rob_entry_t next_entry,
	output logic tail_occupied
);

	rob_entry_pkg::rob_entry_t entries [rob_config_pkg::ENTRY_COUNT];
	rob_config_pkg::rob_index_t head_next;

	assign head_next = head + 1'b1;

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < rob_config_pkg::ENTRY_COUNT; i++)
		begin
			// a squash empties the whole partition
			if (reset || squash || free[i])
			begin
				entries[i].occupied <= 1'b0;
				entries[i].executed <= 1'b0;
			end
			else if (load1[i] || load2[i])
			begin
				entries[i].inst <= load1[i] ? inst1 : inst2;
				entries[i].occupied <= 1'b1;
				entries[i].executed <= 1'b0;
				entries[i].mispredict <= 1'b0;
			end
			else if (done[i])
			begin
				entries[i].executed <= 1'b1;
				entries[i].mispredict <= result[i].mispredict;
				entries[i].target <= result[i].target;
			end
		end
	end

	assign head_entry = entries[head];
	assign next_entry = entries[head_next];	// wraps past the last entry
	assign tail_occupied = entries[tail].occupied;

endmodule

//--- logic/rob_entry_pkg.sv
// packed records that travel between dispatch, completion, entry storage and commit
package rob_entry_pkg;

	// one instruction as it arrives from dispatch
	typedef struct packed {
		rob_config_pkg::pc_t pc;
		rob_config_pkg::arn_t arn_dest;
		rob_config_pkg::prn_t prn_dest;
		logic is_branch;
	} dispatch_slot_t;

	// report from one functional unit port
	typedef struct packed {
		logic valid;
		rob_config_pkg::rob_tag_t tag;
		logic mispredict;
		rob_config_pkg::pc_t target;
	} completion_t;

	// what a completion writes into one entry
	typedef struct packed {
		logic mispredict;
		rob_config_pkg::pc_t target;
	} result_t;

	// stored state of one buffer entry
	typedef struct packed {
		dispatch_slot_t inst;
		logic occupied;
		logic executed;
		logic mispredict;
		rob_config_pkg::pc_t target;
	} rob_entry_t;

	// one retiring instruction as seen by the commit side
	typedef struct packed {
		logic valid;
		logic is_thread1;
		rob_config_pkg::pc_t pc;
		rob_config_pkg::pc_t target;
		logic is_branch;
		logic mispredict;
		rob_config_pkg::arn_t arn_dest;
		rob_config_pkg::prn_t prn_dest;
	} commit_slot_t;

endpackage

//--- logic/rob_top.sv
// reorder buffer of a two-thread, two-wide core; connects dispatch, completion, storage and commit
`timescale 1ns/1ps

module rob_top (
	input  logic clock,
	input  logic reset,
	input  logic is_thread1,
	input  rob_entry_pkg::dispatch_slot_t inst1,
	input  rob_entry_pkg::dispatch_slot_t inst2,
	input  logic inst1_load,
	input  logic inst2_load,
	input  rob_entry_pkg::completion_t fu1,
	input  rob_entry_pkg::completion_t fu2,
	output rob_config_pkg::rob_tag_t inst1_tag,
	output rob_config_pkg::rob_tag_t inst2_tag,
	output rob_entry_pkg::commit_slot_t commit1,
	output rob_entry_pkg::commit_slot_t commit2,
	output logic t1_full,
	output logic t2_full
);

	rob_config_pkg::rob_index_t t1_head, t2_head;
	rob_config_pkg::rob_index_t t1_tail, t2_tail;
	rob_config_pkg::rob_index_t t1_new_head, t2_new_head;
	rob_config_pkg::entry_mask_t t1_load1, t1_load2, t2_load1, t2_load2;
	rob_config_pkg::entry_mask_t t1_done, t2_done;
	rob_config_pkg::entry_mask_t t1_free, t2_free;
	rob_entry_pkg::result_t [rob_config_pkg::ENTRY_COUNT-1:0] t1_result, t2_result;
	rob_entry_pkg::rob_entry_t t1_head_entry, t1_next_entry;
	rob_entry_pkg::rob_entry_t t2_head_entry, t2_next_entry;
	logic t1_tail_occupied, t2_tail_occupied;
	logic t1_squash, t2_squash;

	rob_dispatch dispatch_i (
		.clock(clock),
		.reset(reset),
		.is_thread1(is_thread1),
		.inst1_load(inst1_load),
		.inst2_load(inst2_load),
		.t1_head(t1_head),
		.t2_head(t2_head),
		.t1_tail_occupied(t1_tail_occupied),
		.t2_tail_occupied(t2_tail_occupied),
		.t1_squash(t1_squash),
		.t2_squash(t2_squash),
		.t1_new_head(t1_new_head),
		.t2_new_head(t2_new_head),
		.inst1_tag(inst1_tag),
		.inst2_tag(inst2_tag),
		.t1_load1(t1_load1),
		.t1_load2(t1_load2),
		.t2_load1(t2_load1),
		.t2_load2(t2_load2),
		.t1_tail(t1_tail),
		.t2_tail(t2_tail),
		.t1_full(t1_full),
		.t2_full(t2_full)
	);

	rob_complete complete_i (
		.fu1(fu1),
		.fu2(fu2),
		.t1_done(t1_done),
		.t2_done(t2_done),
		.t1_result(t1_result),
		.t2_result(t2_result)
	);

	// thread 1 partition
	rob_entry_bank t1_bank_i (
		.clock(clock),
		.reset(reset),
		.inst1(inst1),
		.inst2(inst2),
		.load1(t1_load1),
		.load2(t1_load2),
		.done(t1_done),
		.result(t1_result),
		.free(t1_free),
		.squash(t1_squash),
		.head(t1_head),
		.tail(t1_tail),
		.head_entry(t1_head_entry),
		.next_entry(t1_next_entry),
		.tail_occupied(t1_tail_occupied)
	);

	// thread 2 partition
	rob_entry_bank t2_bank_i (
		.clock(clock),
		.reset(reset),
		.inst1(inst1),
		.inst2(inst2),
		.load1(t2_load1),
		.load2(t2_load2),
		.done(t2_done),
		.result(t2_result),
		.free(t2_free),
		.squash(t2_squash),
		.head(t2_head),
		.tail(t2_tail),
		.head_entry(t2_head_entry),
		.next_entry(t2_next_entry),
		.tail_occupied(t2_tail_occupied)
	);

	rob_commit commit_i (
		.clock(clock),
		.reset(reset),
		.t1_head_entry(t1_head_entry),
		.t1_next_entry(t1_next_entry),
		.t2_head_entry(t2_head_entry),
		.t2_next_entry(t2_next_entry),
		.commit1(commit1),
		.commit2(commit2),
		.t1_head(t1_head),
		.t2_head(t2_head),
		.t1_free(t1_free),
		.t2_free(t2_free),
		.t1_squash(t1_squash),
		.t2_squash(t2_squash),
		.t1_new_head(t1_new_head),
		.t2_new_head(t2_new_head)
	);

endmodule

//--- run.sh
#!/bin/sh
# builds the reorder buffer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rob_tb -f sim.f -Mdir obj_dir -o rob_sim
if [ $? -ne 0 ]; then
	echo "compile step returned an error"
	exit 1
fi

./obj_dir/rob_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation returned an error"
	exit 1
fi

if grep -q "^test passed$" sim.log; then
	exit 0
fi
exit 1

//--- sim.f
logic/rob_config_pkg.sv
logic/rob_entry_pkg.sv
logic/rob_dispatch.sv
logic/rob_entry_bank.sv
logic/rob_complete.sv
logic/rob_commit.sv
logic/rob_top.sv
verification/rob_tb.sv

//--- verification/rob_tb.sv
// testbench of the reorder buffer; applies a per-cycle table of stimulus and expected outputs to rob_top
`timescale 1ns/1ps

module rob_tb;

	localparam int ROW_COUNT = 32;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLE_LIMIT = RESET_CYCLES + ROW_COUNT + 20;
	localparam int ID_COUNT = 64;

	// one functional-unit report of a row, id selects the target pc
	typedef struct packed {
		logic v;
		rob_config_pkg::rob_tag_t tag;
		logic [5:0] id;
		logic mis;
	} report_row_t;

	// what one commit port should show
	typedef struct packed {
		logic v;
		logic thr1;
		logic [5:0] id;
		logic br;
		logic mis;
	} slot_row_t;

	typedef struct packed {
		logic [2:0] test;
		logic disp;
		logic thr1;
		logic [5:0] id;	// inst1 carries id, inst2 carries id+1
		logic br;	// inst1 is a branch
		logic tag_chk;
		rob_config_pkg::rob_tag_t tag1;
		rob_config_pkg::rob_tag_t tag2;
		report_row_t f1;
		report_row_t f2;
		slot_row_t c1;
		slot_row_t c2;
		logic t1_full;
		logic t2_full;
	} row_t;

	logic clock;
	logic reset;
	logic is_thread1;
	logic inst1_load;
	logic inst2_load;
	rob_entry_pkg::dispatch_slot_t inst1;
	rob_entry_pkg::dispatch_slot_t inst2;
	rob_entry_pkg::completion_t fu1;
	rob_entry_pkg::completion_t fu2;
	rob_config_pkg::rob_tag_t inst1_tag;
	rob_config_pkg::rob_tag_t inst2_tag;
	rob_entry_pkg::commit_slot_t commit1;
	rob_entry_pkg::commit_slot_t commit2;
	logic t1_full;
	logic t2_full;

	row_t rows [ROW_COUNT];
	rob_config_pkg::pc_t pc_of [ID_COUNT];
	rob_config_pkg::pc_t target_of [ID_COUNT];
	int checks = 0;
	int errors = 0;
	int group_checks = 0;
	int group_errors = 0;
	int cycle_count = 0;

	rob_top dut_i (
		.clock(clock),
		.reset(reset),
		.is_thread1(is_thread1),
		.inst1(inst1),
		.inst2(inst2),
		.inst1_load(inst1_load),
		.inst2_load(inst2_load),
		.fu1(fu1),
		.fu2(fu2),
		.inst1_tag(inst1_tag),
		.inst2_tag(inst2_tag),
		.commit1(commit1),
		.commit2(commit2),
		.t1_full(t1_full),
		.t2_full(t2_full)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// register fields derived from the instruction id
	function automatic rob_config_pkg::arn_t arn_of(logic [5:0] id);
		return id[4:0] ^ 5'h0b;
	endfunction

	function automatic rob_config_pkg::prn_t prn_of(logic [5:0] id);
		return id ^ 6'h2d;
	endfunction

	function automatic rob_entry_pkg::dispatch_slot_t make_inst(logic [5:0] id, logic br);
		rob_entry_pkg::dispatch_slot_t slot;
		slot.pc = pc_of[id];
		slot.arn_dest = arn_of(id);
		slot.prn_dest = prn_of(id);
		slot.is_branch = br;
		return slot;
	endfunction

	function automatic rob_entry_pkg::completion_t make_report(report_row_t r);
		rob_entry_pkg::completion_t rep;
		rep = '0;
		if (r.v)
		begin
			rep.valid = 1'b1;
			rep.tag = r.tag;
			rep.mispredict = r.mis;
			rep.target = target_of[r.id];
		end
		return rep;
	endfunction

	task automatic put_tags(int r, logic thr1, rob_config_pkg::rob_tag_t tag1,
		rob_config_pkg::rob_tag_t tag2);
		rows[r].thr1 = thr1;
		rows[r].tag_chk = 1'b1;
		rows[r].tag1 = tag1;
		rows[r].tag2 = tag2;
	endtask

	task automatic put_dispatch(int r, logic thr1, logic [5:0] id, logic br,
		rob_config_pkg::rob_tag_t tag1, rob_config_pkg::rob_tag_t tag2);
		rows[r].disp = 1'b1;
		rows[r].id = id;
		rows[r].br = br;
		put_tags(r, thr1, tag1, tag2);
	endtask

	task automatic put_report(int r, int port, rob_config_pkg::rob_tag_t tag, logic [5:0] id,
		logic mis);
		report_row_t rep;
		rep.v = 1'b1;
		rep.tag = tag;
		rep.id = id;
		rep.mis = mis;
		if (port == 1)
			rows[r].f1 = rep;
		else
			rows[r].f2 = rep;
	endtask

	task automatic expect_commit(int r, int port, logic thr1, logic [5:0] id, logic br, logic mis);
		slot_row_t slot;
		slot.v = 1'b1;
		slot.thr1 = thr1;
		slot.id = id;
		slot.br = br;
		slot.mis = mis;
		if (port == 1)
			rows[r].c1 = slot;
		else
			rows[r].c2 = slot;
	endtask

	task automatic mark_test(int first, int last, int n);
		for (int r = first; r <= last; r++)
			rows[r].test = 3'(n);
	endtask

	task automatic build_table();
		for (int r = 0; r < ROW_COUNT; r++)
			rows[r] = '0;
		put_tags(0, 1'b1, 5'h00, 5'h01);	// reset state, both threads
		put_tags(1, 1'b0, 5'h10, 5'h11);
		// thread 1 pair, younger entry completes first
		put_dispatch(2, 1'b1, 6'd0, 1'b0, 5'h00, 5'h01);
		put_report(3, 1, 5'h01, 6'd1, 1'b0);
		put_report(5, 1, 5'h00, 6'd0, 1'b0);
		expect_commit(6, 1, 1'b1, 6'd0, 1'b0, 1'b0);
		expect_commit(6, 2, 1'b1, 6'd1, 1'b0, 1'b0);
		// both heads ready, then thread 2 alone
		put_dispatch(7, 1'b1, 6'd2, 1'b0, 5'h02, 5'h03);
		put_dispatch(8, 1'b0, 6'd4, 1'b0, 5'h10, 5'h11);
		put_report(9, 1, 5'h02, 6'd2, 1'b0);
		put_report(9, 2, 5'h10, 6'd4, 1'b0);
		expect_commit(10, 1, 1'b1, 6'd2, 1'b0, 1'b0);
		expect_commit(10, 2, 1'b0, 6'd4, 1'b0, 1'b0);
		put_dispatch(10, 1'b0, 6'd6, 1'b0, 5'h12, 5'h13);
		put_report(10, 1, 5'h11, 6'd5, 1'b0);
		expect_commit(11, 1, 1'b0, 6'd5, 1'b0, 1'b0);
		put_report(11, 1, 5'h12, 6'd6, 1'b0);
		put_report(11, 2, 5'h13, 6'd7, 1'b0);
		expect_commit(12, 1, 1'b0, 6'd6, 1'b0, 1'b0);
		expect_commit(12, 2, 1'b0, 6'd7, 1'b0, 1'b0);
		put_report(12, 1, 5'h03, 6'd3, 1'b0);
		expect_commit(13, 1, 1'b1, 6'd3, 1'b0, 1'b0);
		// mispredicted branch at t1 entry 4, its successor is dropped
		put_dispatch(14, 1'b1, 6'd8, 1'b1, 5'h04, 5'h05);
		put_report(15, 1, 5'h04, 6'd8, 1'b1);
		put_report(15, 2, 5'h05, 6'd9, 1'b0);
		expect_commit(16, 1, 1'b1, 6'd8, 1'b1, 1'b1);
		put_dispatch(16, 1'b1, 6'd10, 1'b0, 5'h06, 5'h07);	// refused by the squash
		put_dispatch(17, 1'b1, 6'd12, 1'b0, 5'h05, 5'h06);
		put_report(18, 1, 5'h05, 6'd12, 1'b0);
		put_report(18, 2, 5'h06, 6'd13, 1'b0);
		expect_commit(19, 1, 1'b1, 6'd12, 1'b0, 1'b0);
		expect_commit(19, 2, 1'b1, 6'd13, 1'b0, 1'b0);
		// eight pairs leave thread 2 with no free entry
		for (int p = 0; p < 8; p++)
			put_dispatch(20 + p, 1'b0, 6'(14 + 2 * p), 1'b0, {1'b1, 4'(4 + 2 * p)},
				{1'b1, 4'(5 + 2 * p)});
		put_dispatch(28, 1'b0, 6'd30, 1'b0, 5'h14, 5'h15);
		put_report(28, 1, 5'h14, 6'd14, 1'b0);
		put_report(28, 2, 5'h15, 6'd15, 1'b0);
		rows[28].t2_full = 1'b1;
		rows[29].t2_full = 1'b1;
		expect_commit(29, 1, 1'b0, 6'd14, 1'b0, 1'b0);
		expect_commit(29, 2, 1'b0, 6'd15, 1'b0, 1'b0);
		mark_test(0, 1, 1);
		mark_test(2, 6, 2);
		mark_test(7, 13, 3);
		mark_test(14, 19, 4);
		mark_test(20, ROW_COUNT - 1, 5);
	endtask

	task automatic apply_row(row_t row);
		is_thread1 <= row.thr1;
		inst1_load <= row.disp;
		inst2_load <= row.disp;
		inst1 <= make_inst(row.id, row.br);
		inst2 <= make_inst(6'(row.id + 6'd1), 1'b0);
		fu1 <= make_report(row.f1);
		fu2 <= make_report(row.f2);
	endtask

	task automatic check_value(string name, logic [63:0] got, logic [63:0] want);
		checks++;
		group_checks++;
		assert (got === want)
		else
		begin
			$display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
			errors++;
			group_errors++;
		end
	endtask

	task automatic check_slot(string port, rob_entry_pkg::commit_slot_t got, slot_row_t want);
		check_value({port, ".valid"}, got.valid, want.v);
		if (want.v)
		begin
			check_value({port, ".is_thread1"}, got.is_thread1, want.thr1);
			check_value({port, ".pc"}, got.pc, pc_of[want.id]);
			check_value({port, ".target"}, got.target, target_of[want.id]);
			check_value({port, ".is_branch"}, got.is_branch, want.br);
			check_value({port, ".mispredict"}, got.mispredict, want.mis);
			check_value({port, ".arn_dest"}, got.arn_dest, arn_of(want.id));
			check_value({port, ".prn_dest"}, got.prn_dest, prn_of(want.id));
		end
	endtask

	task automatic check_row(row_t row);
		if (row.tag_chk)
		begin
			check_value("inst1_tag", inst1_tag, row.tag1);
			check_value("inst2_tag", inst2_tag, row.tag2);
		end
		check_slot("commit1", commit1, row.c1);
		check_slot("commit2", commit2, row.c2);
		check_value("t1_full", t1_full, row.t1_full);
		check_value("t2_full", t2_full, row.t2_full);
	endtask

	function automatic string test_title(int n);
		case (n)
			1: return "reset state";
			2: return "in-order commit";
			3: return "thread selection";
			4: return "mispredict squash";
			default: return "full flag";
		endcase
	endfunction

	task automatic report_group(int n);
		$display("%0d %s: %0d checks, %0d errors", n, test_title(n), group_checks, group_errors);
		group_checks = 0;
		group_errors = 0;
	endtask

	initial
	begin
		reset = 1'b1;
		is_thread1 = 1'b0;
		inst1_load = 1'b0;
		inst2_load = 1'b0;
		inst1 = '0;
		inst2 = '0;
		fu1 = '0;
		fu2 = '0;
		void'($urandom(32'hf99a));
		for (int i = 0; i < ID_COUNT; i++)
		begin
			pc_of[i] = {$urandom, $urandom} & ~64'h3;	// word aligned
			target_of[i] = {$urandom, $urandom} & ~64'h3;
		end
		build_table();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (int r = 0; r < ROW_COUNT; r++)
		begin
			if (r > 0 && rows[r].test != rows[r - 1].test)
				report_group(rows[r - 1].test);
			@(posedge clock);
			apply_row(rows[r]);
			@(negedge clock);	// outputs settled
			check_row(rows[r]);
		end
		report_group(rows[ROW_COUNT - 1].test);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

endmodule
